// File: ascii_counter.sv
`timescale 1ns/100ps
`default_nettype none

module ascii_counter (
    input  logic tck,
    input  logic reset,
    suffix_if.source suffix
);
    import md5_pkg::*;

    suffix_ascii_t number_q;
    suffix_digits_t digits_q;
    suffix_ascii_t number_next;
    suffix_digits_t digits_next;
    logic carry;

    // Decimal increment, least significant digit sits at byte digits_q-1
    always_comb begin
        number_next = number_q;
        digits_next = digits_q;
        carry = 1'b1;
        for (int i = suffix_digits_max - 1; i >= 0; i--) begin
            if (carry && (i < int'(digits_q))) begin
                if (number_q[i*byte_width +: byte_width] == ascii_nine) begin
                    number_next[i*byte_width +: byte_width] = ascii_zero;
                end else begin
                    number_next[i*byte_width +: byte_width] =
                        number_q[i*byte_width +: byte_width] + 1'b1;
                    carry = 1'b0;
                end
            end
        end
        if (carry) begin
            if (digits_q == suffix_digits_t'(suffix_digits_max)) begin
                number_next = suffix_ascii_t'(ascii_one);   // Wrap after all nines
                digits_next = suffix_digits_t'(1);
            end else begin
                // Zeros move one byte up, new leading one in front
                number_next = {number_next[byte_width*(suffix_digits_max-1)-1:0], ascii_one};
                digits_next = digits_q + 1'b1;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (reset) begin
            suffix.valid <= 1'b0;
            number_q <= suffix_ascii_t'(ascii_one);          // Count starts at "1"
            digits_q <= suffix_digits_t'(1);
        end else begin
            suffix.valid <= 1'b1;
            if (suffix.valid && suffix.ready) begin
                number_q <= number_next;
                digits_q <= digits_next;
            end
        end
    end

    assign suffix.number = number_q;
    assign suffix.digits = digits_q;

endmodule

`default_nettype wire

// File: build.f
md5_pkg.sv
md5_stream_if.sv
tap_decoder.sv
line_decoder.sv
ascii_counter.sv
message_concat.sv
message_length_inserter.sv
tap_encoder.sv
user_logic.sv
user_logic_asserts.sv
tb_user_logic.sv

// File: line_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module line_decoder (
    input  logic tck,
    input  logic reset,
    input  logic inbound_valid,
    input  logic alignment_error,
    input  md5_pkg::inbound_data_t inbound_data,
    output logic key_valid,
    output md5_pkg::secret_key_chars_t key_chars,
    output md5_pkg::secret_key_t key_value
);
    import md5_pkg::*;

    typedef enum logic {
        collect,
        done
    } line_state_t;

    line_state_t state;
    secret_key_chars_t char_count;
    logic is_newline;
    logic store_char;

    assign is_newline = (inbound_data == newline_char);

    // Characters past the twelfth are dropped
    assign store_char = (state == collect) && inbound_valid && !alignment_error &&
                        !is_newline && (char_count < key_max_chars);

    always_ff @(posedge tck) begin
        if (reset) begin
            state <= collect;
            char_count <= '0;
        end else begin
            case (state)
                collect: begin
                    if (alignment_error) begin
                        char_count <= '0;       // Misaligned scan discards the partial key
                    end else if (inbound_valid && is_newline) begin
                        state <= done;
                    end else if (store_char) begin
                        char_count <= char_count + 1'b1;
                    end
                end
                done: begin
                    state <= done;              // Held until reset
                end
                default: begin
                    state <= collect;
                end
            endcase
        end
    end

    always_ff @(posedge tck) begin
        if (store_char) begin
            key_value[char_count*byte_width +: byte_width] <= inbound_data;
        end
    end

    assign key_valid = (state == done);
    assign key_chars = char_count;

endmodule

`default_nettype wire

// File: md5_pkg.sv
`default_nettype none

package md5_pkg;

    // JTAG framing
    localparam int upstream_bypass_bits = 1;    // One bypass device ahead in the chain
    localparam int byte_width = 8;

    // Message sizes
    localparam int key_max_chars = 12;
    localparam int suffix_digits_max = 7;
    localparam int block_bytes = 64;
    localparam int msg_max_bytes = 56;          // Bytes left ahead of the length field
    localparam int length_field_bits = byte_width * (block_bytes - msg_max_bytes);
    localparam int result_width = 16;

    // Byte values
    localparam logic [byte_width-1:0] newline_char = 8'h0A;
    localparam logic [byte_width-1:0] pad_marker = 8'h80;
    localparam logic [byte_width-1:0] ascii_zero = 8'h30;
    localparam logic [byte_width-1:0] ascii_one = 8'h31;
    localparam logic [byte_width-1:0] ascii_nine = 8'h39;

    typedef logic [byte_width-1:0] inbound_data_t;

    // First key character in the lowest byte
    typedef logic [byte_width*key_max_chars-1:0] secret_key_t;
    typedef logic [$clog2(key_max_chars+1)-1:0] secret_key_chars_t;

    // Most significant digit in the lowest byte
    typedef logic [byte_width*suffix_digits_max-1:0] suffix_ascii_t;
    typedef logic [$clog2(suffix_digits_max+1)-1:0] suffix_digits_t;

    // Byte k at bits 8k up to 8k+7
    typedef logic [$clog2(msg_max_bytes+1)-1:0] msg_length_t;
    typedef logic [byte_width*msg_max_bytes-1:0] msg_data_t;
    typedef logic [byte_width*block_bytes-1:0] md5_block_t;

    typedef logic [result_width-1:0] result_t;

endpackage

`default_nettype wire

// File: md5_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// Suffix stream from the decimal counter
interface suffix_if;
    import md5_pkg::*;

    logic valid;
    logic ready;
    suffix_digits_t digits;     // Significant digit count
    suffix_ascii_t number;      // Left-aligned digits

    modport source (output valid, output digits, output number, input ready);
    modport sink (input valid, input digits, input number, output ready);
endinterface

// Concatenated message ahead of padding
interface msg_if;
    import md5_pkg::*;

    logic valid;
    logic ready;
    msg_length_t length;        // Bytes
    msg_data_t data;

    modport source (output valid, output length, output data, input ready);
    modport sink (input valid, input length, input data, output ready);
endinterface

`default_nettype wire

// File: message_concat.sv
`timescale 1ns/100ps
`default_nettype none

module message_concat (
    input  logic tck,
    input  logic reset,
    input  logic key_valid,
    input  md5_pkg::secret_key_chars_t key_chars,
    input  md5_pkg::secret_key_t key_value,
    suffix_if.sink suffix,
    msg_if.source msg
);
    import md5_pkg::*;

    msg_data_t joined;
    msg_length_t joined_length;
    logic take_suffix;

    // Stage is free when empty or drained this cycle
    assign suffix.ready = key_valid && (!msg.valid || msg.ready);
    assign take_suffix = suffix.valid && suffix.ready;

    assign joined_length = msg_length_t'(key_chars) + msg_length_t'(suffix.digits);

    always_comb begin
        joined = '0;

        // Key bytes first
        for (int k = 0; k < key_max_chars; k++) begin
            if (k < int'(key_chars)) begin
                joined[k*byte_width +: byte_width] = key_value[k*byte_width +: byte_width];
            end
        end

        // Suffix right behind the key
        for (int d = 0; d < suffix_digits_max; d++) begin
            if (d < int'(suffix.digits)) begin
                joined[(int'(key_chars) + d)*byte_width +: byte_width] =
                    suffix.number[d*byte_width +: byte_width];
            end
        end
    end

    always_ff @(posedge tck) begin
        if (reset) begin
            msg.valid <= 1'b0;
        end else if (take_suffix) begin
            msg.valid <= 1'b1;
        end else if (msg.ready) begin
            msg.valid <= 1'b0;
        end
    end

    always_ff @(posedge tck) begin
        if (take_suffix) begin
            msg.data <= joined;
            msg.length <= joined_length;
        end
    end

endmodule

`default_nettype wire

// File: message_length_inserter.sv
`timescale 1ns/100ps
`default_nettype none

module message_length_inserter (
    input  logic tck,
    input  logic reset,
    msg_if.sink msg,
    output logic block_valid,
    input  logic block_ready,
    output md5_pkg::md5_block_t block_data
);
    import md5_pkg::*;

    md5_block_t padded;
    logic take_msg;

    assign msg.ready = !block_valid || block_ready;
    assign take_msg = msg.valid && msg.ready;

    always_comb begin
        padded = '0;
        for (int k = 0; k < msg_max_bytes; k++) begin
            if (k < int'(msg.length)) begin
                padded[k*byte_width +: byte_width] = msg.data[k*byte_width +: byte_width];
            end else if (k == int'(msg.length)) begin
                padded[k*byte_width +: byte_width] = pad_marker;   // End of message marker
            end
        end
        // Bit count, little endian in the last eight bytes
        padded[msg_max_bytes*byte_width +: length_field_bits] =
            length_field_bits'(msg.length) << 3;
    end

    always_ff @(posedge tck) begin
        if (reset) begin
            block_valid <= 1'b0;
        end else if (take_msg) begin
            block_valid <= 1'b1;
        end else if (block_ready) begin
            block_valid <= 1'b0;
        end
    end

    always_ff @(posedge tck) begin
        if (take_msg) begin
            block_data <= padded;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log

rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module tb_user_logic \
    -o sim_user_logic \
    && ./obj_dir/sim_user_logic > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Finished with no errors" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tap_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module tap_decoder (
    input  logic tck,
    input  logic reset,
    input  logic tdi,
    input  logic shift_dr,
    input  logic update_dr,
    output logic inbound_valid,
    output logic alignment_error,
    output md5_pkg::inbound_data_t inbound_data
);
    import md5_pkg::*;

    logic [$clog2(upstream_bypass_bits+1)-1:0] bypass_count;
    logic [$clog2(byte_width)-1:0] bit_index;  // Position inside the current byte
    logic bypass_done;
    inbound_data_t shift_byte;

    assign bypass_done = (bypass_count == upstream_bypass_bits);

    always_ff @(posedge tck) begin
        if (reset) begin
            bypass_count <= '0;
            bit_index <= '0;
            inbound_valid <= 1'b0;
            alignment_error <= 1'b0;
        end else begin
            inbound_valid <= 1'b0;
            alignment_error <= 1'b0;
            if (update_dr) begin
                alignment_error <= (bit_index != '0);   // Scan ended inside a byte
                bypass_count <= '0;
                bit_index <= '0;
            end else if (shift_dr) begin
                if (!bypass_done) begin
                    bypass_count <= bypass_count + 1'b1;  // Leading bypass bit is dropped
                end else begin
                    bit_index <= bit_index + 1'b1;
                    if (&bit_index) begin
                        inbound_valid <= 1'b1;           // Eighth bit just arrived
                    end
                end
            end
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge tck) begin
        if (shift_dr && bypass_done) begin
            shift_byte <= {tdi, shift_byte[byte_width-1:1]};
        end
    end

    assign inbound_data = shift_byte;     // Stable for the cycle of the valid pulse

endmodule

`default_nettype wire

// File: tap_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module tap_encoder (
    input  logic tck,
    input  logic reset,
    input  logic block_valid,
    output logic block_ready,
    input  md5_pkg::md5_block_t block_data,
    input  logic capture_dr,
    input  logic shift_dr,
    output logic tdo
);
    import md5_pkg::*;

    logic result_full;
    result_t result_q;
    result_t signature;
    logic [result_width:0] shift_word;     // Valid flag in bit 0

    // Stand-in for the digest
    assign signature = result_t'(1) +
        result_t'($countones(block_data[msg_max_bytes*byte_width +: length_field_bits])) +
        result_t'($countones(block_data));

    assign block_ready = !result_full;

    always_ff @(posedge tck) begin
        if (reset) begin
            result_full <= 1'b0;
            shift_word <= '0;
        end else begin
            if (capture_dr && result_full) begin
                result_full <= 1'b0;            // Host has taken it
            end else if (block_valid && block_ready) begin
                result_full <= 1'b1;
            end

            if (capture_dr) begin
                shift_word <= {result_q, result_full};
            end else if (shift_dr) begin
                shift_word <= shift_word >> 1;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (block_valid && block_ready) begin
            result_q <= signature;
        end
    end

    assign tdo = shift_word[0];

endmodule

`default_nettype wire

// File: tb_user_logic.sv
`timescale 1ns/100ps
`default_nettype none

module tb_user_logic;
    import md5_pkg::*;

    localparam int clk_period = 40;
    localparam int reset_cycles = 8;
    localparam int read_timeout_scans = 20;
    localparam int max_cycles = 20000;

    logic tck = 1'b0;
    logic tdi;
    logic test_logic_reset;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;

    inbound_data_t ref_key[$];      // Key as the DUT should hold it
    inbound_data_t scan_queue[$];   // Bytes of the next key scan
    int next_suffix;

    user_logic user_logic_i (
        .tck(tck),
        .tdi(tdi),
        .test_logic_reset(test_logic_reset),
        .ir_is_user(ir_is_user),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .tdo(tdo)
    );

    always #(clk_period / 2) tck = ~tck;

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_result(input string test_name, input result_t expected,
                                input result_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string test_name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s valid flag: expected %b, actual %b", test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic apply_reset();
        @(negedge tck);
        test_logic_reset = 1'b1;
        repeat (reset_cycles) @(negedge tck);
        test_logic_reset = 1'b0;
        next_suffix = 1;                // Counter restarts at "1"
    endtask

    // Bypass bit, then the queued bytes LSB first, then extra_bits of padding
    task automatic scan_bytes(input int extra_bits);
        @(negedge tck);
        capture_dr = 1'b1;
        @(negedge tck);
        capture_dr = 1'b0;
        shift_dr = 1'b1;
        tdi = 1'b0;                     // Upstream bypass bit
        foreach (scan_queue[i]) begin
            for (int b = 0; b < byte_width; b++) begin
                @(negedge tck);
                tdi = scan_queue[i][b];
            end
        end
        for (int b = 0; b < extra_bits; b++) begin
            @(negedge tck);
            tdi = 1'b0;
        end
        @(negedge tck);
        shift_dr = 1'b0;
        tdi = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
    endtask

    // One 17-bit status scan, flag in bit 0
    task automatic scan_status(output logic [result_width:0] word);
        @(negedge tck);
        capture_dr = 1'b1;
        @(negedge tck);
        capture_dr = 1'b0;
        shift_dr = 1'b1;
        tdi = 1'b0;
        word[0] = tdo;
        for (int i = 1; i <= result_width; i++) begin
            @(negedge tck);
            word[i] = tdo;
        end
        @(negedge tck);
        shift_dr = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
    endtask

    // Flag stays 0 if no result shows up within the scan limit
    task automatic read_result(output logic flag, output result_t value);
        logic [result_width:0] word;
        int scans;
        scans = 1;
        scan_status(word);
        while (!word[0] && scans < read_timeout_scans) begin
            scans++;
            scan_status(word);
        end
        flag = word[0];
        value = word[result_width:1];
    endtask

    task automatic load_key(input string text);
        ref_key.delete();
        scan_queue.delete();
        for (int i = 0; i < text.len(); i++) begin
            ref_key.push_back(inbound_data_t'(text[i]));
            scan_queue.push_back(inbound_data_t'(text[i]));
        end
        scan_queue.push_back(newline_char);
    endtask

    // Padded block of key plus decimal suffix, then the signature rule
    function automatic result_t reference_signature(input int suffix_value);
        string digits;
        logic [7:0] blk [0:63];
        int length;
        logic [63:0] bit_length;
        int length_ones;
        int block_ones;
        digits = $sformatf("%0d", suffix_value);
        for (int k = 0; k < 64; k++) begin
            blk[k] = 8'h00;
        end
        foreach (ref_key[k]) begin
            blk[k] = ref_key[k];
        end
        for (int d = 0; d < digits.len(); d++) begin
            blk[ref_key.size() + d] = digits[d];
        end
        length = ref_key.size() + digits.len();
        blk[length] = 8'h80;            // Marker right behind the message
        bit_length = 64'(length) * 64'd8;
        for (int k = 0; k < 8; k++) begin
            blk[56 + k] = bit_length[8*k +: 8];
        end
        length_ones = $countones(bit_length);
        block_ones = 0;
        for (int k = 0; k < 64; k++) begin
            block_ones += $countones(blk[k]);
        end
        return result_t'(1 + length_ones + block_ones);
    endfunction

    task automatic expect_results(input string label, input int count);
        logic flag;
        result_t value;
        string name;
        for (int i = 0; i < count; i++) begin
            read_result(flag, value);
            name = $sformatf("%s suffix %0d", label, next_suffix);
            check_flag(name, 1'b1, flag);
            check_result(name, reference_signature(next_suffix), value);
            next_suffix++;
        end
    endtask

    task automatic no_key_status();
        logic flag;
        result_t value;
        apply_reset();
        read_result(flag, value);
        check_flag("no key", 1'b0, flag);
    endtask

    task automatic short_key_sequence();
        apply_reset();              // Read scans above fed null bytes into the key
        load_key("abc");
        scan_bytes(0);
        expect_results("abc", 3);
    endtask

    // Continues from "abc3" up past "9"
    task automatic suffix_rollover();
        expect_results("abc rollover", 12);
    endtask

    task automatic long_key_truncation();
        apply_reset();
        ref_key.delete();
        scan_queue.delete();
        for (int k = 0; k < key_max_chars; k++) begin
            ref_key.push_back(inbound_data_t'(8'h61 + ($urandom % 26)));
            scan_queue.push_back(ref_key[k]);
        end
        for (int k = 0; k < 3; k++) begin
            scan_queue.push_back(inbound_data_t'(8'h41 + ($urandom % 26)));   // Dropped
        end
        scan_queue.push_back(newline_char);
        scan_bytes(0);
        expect_results("long key", 3);
    endtask

    task automatic misaligned_scan_recovery();
        apply_reset();
        scan_queue.delete();
        scan_queue.push_back(8'h7A);
        scan_queue.push_back(8'h7A);
        scan_bytes(5);              // Ends inside a byte
        load_key("clean");
        scan_bytes(0);
        expect_results("clean key", 2);
        apply_reset();
        load_key("xy9");
        scan_bytes(0);
        expect_results("new key", 2);
    endtask

    initial begin
        repeat (max_cycles) @(posedge tck);
        $display("Simulation ran past %0d cycles without finishing", max_cycles);
        abort_run();
    end

    initial begin
        tdi = 1'b0;
        test_logic_reset = 1'b1;
        ir_is_user = 1'b1;
        capture_dr = 1'b0;
        shift_dr = 1'b0;
        update_dr = 1'b0;
        next_suffix = 1;
        void'($urandom(57));

        no_key_status();
        short_key_sequence();
        suffix_rollover();
        long_key_truncation();
        misaligned_scan_recovery();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: user_logic.sv
`timescale 1ns/100ps
`default_nettype none

module user_logic (
    input  logic tck,
    input  logic tdi,
    input  logic test_logic_reset,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo
);
    import md5_pkg::*;

    logic reset;

    logic inbound_valid;
    logic alignment_error;
    inbound_data_t inbound_data;

    logic key_valid;
    secret_key_chars_t key_chars;
    secret_key_t key_value;

    logic block_valid;
    logic block_ready;
    md5_block_t block_data;

    // Held in reset unless the user instruction is loaded
    assign reset = test_logic_reset || !ir_is_user;

    suffix_if suffix_bus ();
    msg_if msg_bus ();

    tap_decoder tap_decoder_i (
        .tck(tck),
        .reset(reset),
        .tdi(tdi),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .inbound_valid(inbound_valid),
        .alignment_error(alignment_error),
        .inbound_data(inbound_data)
    );

    line_decoder line_decoder_i (
        .tck(tck),
        .reset(reset),
        .inbound_valid(inbound_valid),
        .alignment_error(alignment_error),
        .inbound_data(inbound_data),
        .key_valid(key_valid),
        .key_chars(key_chars),
        .key_value(key_value)
    );

    // Counts independently of the key decode
    ascii_counter ascii_counter_i (
        .tck(tck),
        .reset(reset),
        .suffix(suffix_bus.source)
    );

    message_concat message_concat_i (
        .tck(tck),
        .reset(reset),
        .key_valid(key_valid),
        .key_chars(key_chars),
        .key_value(key_value),
        .suffix(suffix_bus.sink),
        .msg(msg_bus.source)
    );

    message_length_inserter message_length_inserter_i (
        .tck(tck),
        .reset(reset),
        .msg(msg_bus.sink),
        .block_valid(block_valid),
        .block_ready(block_ready),
        .block_data(block_data)
    );

    tap_encoder tap_encoder_i (
        .tck(tck),
        .reset(reset),
        .block_valid(block_valid),
        .block_ready(block_ready),
        .block_data(block_data),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .tdo(tdo)
    );

endmodule

`default_nettype wire

// File: user_logic_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module user_logic_asserts (
    input logic tck,
    input logic reset,
    input logic valid,
    input logic ready,
    input md5_pkg::md5_block_t data,
    input md5_pkg::msg_length_t length
);
    import md5_pkg::*;

    // Valid stays up until the transfer
    valid_held: assert property (@(posedge tck) disable iff (reset)
        valid && !ready |=> valid)
        else $error("valid dropped before the transfer");

    data_stable: assert property (@(posedge tck) disable iff (reset)
        valid && !ready |=> $stable(data) && $stable(length))
        else $error("stream data changed while waiting for ready");

    length_bound: assert property (@(posedge tck) disable iff (reset)
        valid |-> length <= msg_length_t'(msg_max_bytes))
        else $error("message length above the block limit");

endmodule

// Message stream out of the concatenation stage
bind message_concat user_logic_asserts msg_stream_asserts_i (
    .tck(tck),
    .reset(reset),
    .valid(msg.valid),
    .ready(msg.ready),
    .data(md5_pkg::md5_block_t'(msg.data)),
    .length(msg.length)
);

// Padded block stream, length recovered from the bit count field
bind message_length_inserter user_logic_asserts block_stream_asserts_i (
    .tck(tck),
    .reset(reset),
    .valid(block_valid),
    .ready(block_ready),
    .data(block_data),
    .length(md5_pkg::msg_length_t'(
        block_data[md5_pkg::msg_max_bytes*md5_pkg::byte_width +: md5_pkg::length_field_bits]
        >> 3))
);

`default_nettype wire
